/* verilog/qspi_pkg.sv */
/*
 * quad-SPI controller shared definitions
 * widths, transfer size, sequencer states and nibble counts
 */
`default_nettype none

package qspi_pkg;

	localparam int ADR_W = 24;
	localparam int DATA_W = 32;
	localparam int NIB_W = 4;
	localparam int ADR_NIBBLES = 6;

	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} xfer_size_t;

	typedef enum logic [2:0] {
		idle   = 3'd0,
		cmd    = 3'd1,
		adr    = 3'd2,
		wdat   = 3'd3,
		rdwait = 3'd4,
		rddat  = 3'd5
	} qspi_state_t;

	// two nibbles per byte
	function automatic logic [3:0] data_nibbles(input xfer_size_t size);
		case (size)
			size_byte: return 4'd2;
			size_half: return 4'd4;
			default: return 4'd8;
		endcase
	endfunction

endpackage

`default_nettype wire

/* verilog/qspi_xfer_if.sv */
/*
 * quad-SPI transfer handoff
 * one latched request from the host side to the sequencer and shifter
 */
`timescale 1ns/1ps
`default_nettype none

interface qspi_xfer_if;

	// levels, held until done
	logic start_read;
	logic start_write;
	qspi_pkg::xfer_size_t size;
	logic [qspi_pkg::ADR_W-1:0] adr;
	logic [qspi_pkg::DATA_W-1:0] wdata;
	logic done;

	modport host (output start_read, start_write, size, adr, wdata, input done);
	modport seq (input start_read, start_write, size, output done);
	modport shift (input size, adr, wdata);

endinterface

`default_nettype wire

/* verilog/qspi_sck_gen.sv */
/*
 * quad-SPI clock generator
 * divides clk down to SCK and gives rise and fall strobes
 */
`timescale 1ns/1ps
`default_nettype none

module qspi_sck_gen #(
	parameter int SCK_DIV = 3
) (
	input  logic clk,
	input  logic rst_n,
	output logic sck,
	output logic rise_edge,
	output logic fall_edge
);

	localparam int CNT_W = $clog2(SCK_DIV + 1);

	logic [CNT_W-1:0] div_cnt;
	logic half_tick;
	logic sck_dly;

	assign half_tick = (div_cnt == CNT_W'(SCK_DIV));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			div_cnt <= '0;
		else if (half_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// idles high between transfers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck <= 1'b1;
			sck_dly <= 1'b1;
		end else begin
			if (half_tick)
				sck <= ~sck;
			sck_dly <= sck;
		end
	end

	assign rise_edge = sck & ~sck_dly;
	assign fall_edge = ~sck & sck_dly;

	// read data needs three clks through the synchronizer before rise_edge
	sck_div_min: assert property (@(posedge clk) disable iff (!rst_n) SCK_DIV >= 3)
		else $error("SCK_DIV below 3 breaks read sampling");

endmodule

`default_nettype wire

/* verilog/qspi_host_if.sv */
/*
 * quad-SPI host side
 * accepts read/write requests, latches the transfer and reports busy
 */
`timescale 1ns/1ps
`default_nettype none

module qspi_host_if
	import qspi_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic read_req,
	input  logic write_req,
	input  xfer_size_t size,
	input  logic [ADR_W-1:0] adr,
	input  logic [DATA_W-1:0] wdata,
	qspi_xfer_if.host xfer,
	output logic busy
);

	logic accept;

	assign busy = xfer.start_read | xfer.start_write;
	assign accept = (read_req | write_req) & ~busy;

	// read wins when both requests come together
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xfer.start_read <= 1'b0;
			xfer.start_write <= 1'b0;
		end else if (accept) begin
			xfer.start_read <= read_req;
			xfer.start_write <= ~read_req;
		end else if (xfer.done) begin
			xfer.start_read <= 1'b0;
			xfer.start_write <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			xfer.size <= size;
			xfer.adr <= adr;
			xfer.wdata <= wdata;
		end
	end

	// no queueing, requests while busy are dropped
	req_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !(read_req || write_req))
		else $warning("request while busy ignored");

endmodule

`default_nettype wire

/* verilog/qspi_sequencer.sv */
/*
 * quad-SPI transfer sequencer
 * command, address, data and dummy phases stepped on SCK falling edges
 */
`timescale 1ns/1ps
`default_nettype none

module qspi_sequencer
	import qspi_pkg::*;
#(
	parameter int READ_DUMMY = 6,
	parameter logic [7:0] READ_CMD = 8'heb,
	parameter logic [7:0] WRITE_CMD = 8'h38
) (
	input  logic clk,
	input  logic rst_n,
	input  logic fall_edge,
	qspi_xfer_if.seq xfer,
	output qspi_state_t state,
	output logic [2:0] idx,
	output logic [7:0] cmd_byte,
	output logic ce_n
);

	localparam logic [2:0] ADR_LAST = 3'(ADR_NIBBLES - 1);
	localparam logic [2:0] DUMMY_LAST = 3'(READ_DUMMY - 1);

	qspi_state_t state_nxt;
	logic [2:0] idx_nxt;
	logic [2:0] data_last;
	logic idx_end;

	assign data_last = 3'(data_nibbles(xfer.size) - 4'd1);
	assign idx_end = (idx == 3'd0);
	assign cmd_byte = xfer.start_read ? READ_CMD : WRITE_CMD;

	// each phase loads idx with its length minus one
	always_comb begin
		state_nxt = state;
		idx_nxt = idx - 3'd1;
		case (state)
			idle: begin
				idx_nxt = 3'd7;
				if (xfer.start_read | xfer.start_write)
					state_nxt = cmd;
			end
			cmd: if (idx_end) begin
				state_nxt = adr;
				idx_nxt = ADR_LAST;
			end
			adr: if (idx_end) begin
				if (xfer.start_read) begin
					state_nxt = rdwait;
					idx_nxt = DUMMY_LAST;
				end else begin
					state_nxt = wdat;
					idx_nxt = data_last;
				end
			end
			rdwait: if (idx_end) begin
				state_nxt = rddat;
				idx_nxt = data_last;
			end
			wdat, rddat: if (idx_end)
				state_nxt = idle;
			default: state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			idx <= 3'd7;
		end else if (fall_edge) begin
			state <= state_nxt;
			idx <= idx_nxt;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ce_n <= 1'b1;
		else
			ce_n <= (state == idle);
	end

	assign xfer.done = fall_edge & idx_end & ((state == wdat) | (state == rddat));

	no_wdat_on_read: assert property (@(posedge clk) disable iff (!rst_n)
		(state == wdat) |-> !xfer.start_read)
		else $error("write data phase during a read");

endmodule

`default_nettype wire

/* verilog/qspi_shifter.sv */
/*
 * quad-SPI data path
 * drives command/address/write nibbles, samples and orders read data
 */
`timescale 1ns/1ps
`default_nettype none

module qspi_shifter
	import qspi_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic rise_edge,
	input  qspi_state_t state,
	input  logic [2:0] idx,
	input  logic [7:0] cmd_byte,
	qspi_xfer_if.shift xfer,
	input  logic [NIB_W-1:0] sio_i,
	output logic [NIB_W-1:0] sio_o,
	output logic sio_en,
	output logic [DATA_W-1:0] read_data
);

	logic [NIB_W-1:0] sio_mt0;
	logic [NIB_W-1:0] sio_mt1;
	logic [NIB_W-1:0] sio_sync;
	logic [DATA_W-1:0] rd_shift;
	logic [2:0] nib_last;
	logic [2:0] nib_num;
	logic [NIB_W-1:0] adr_nib;
	logic [NIB_W-1:0] wr_nib;
	logic [NIB_W-1:0] sio_nxt;

	assign nib_last = 3'(data_nibbles(xfer.size) - 4'd1);
	assign nib_num = nib_last - idx;

	// address msb nibble first
	assign adr_nib = xfer.adr[{idx, 2'b00} +: NIB_W];
	// byte 0 upward, high nibble of each byte first
	assign wr_nib = xfer.wdata[{nib_num[2:1], ~nib_num[0], 2'b00} +: NIB_W];

	always_comb begin
		case (state)
			cmd: sio_nxt = {3'b000, cmd_byte[idx]};
			adr: sio_nxt = adr_nib;
			wdat: sio_nxt = wr_nib;
			default: sio_nxt = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sio_o <= '0;
			sio_en <= 1'b0;
		end else begin
			sio_o <= sio_nxt;
			sio_en <= (state == cmd) | (state == adr) | (state == wdat);
		end
	end

	// three flops ahead of the sampling point
	always_ff @(posedge clk) begin
		sio_mt0 <= sio_i;
		sio_mt1 <= sio_mt0;
		sio_sync <= sio_mt1;
		if (rise_edge && state == rddat)
			rd_shift <= {rd_shift[DATA_W-NIB_W-1:0], sio_sync};
	end

	// first received byte sits highest in rd_shift
	always_comb begin
		case (xfer.size)
			size_byte: read_data = {24'd0, rd_shift[7:0]};
			size_half: read_data = {16'd0, rd_shift[7:0], rd_shift[15:8]};
			default: read_data = {rd_shift[7:0], rd_shift[15:8], rd_shift[23:16],
				rd_shift[31:24]};
		endcase
	end

endmodule

`default_nettype wire

/* verilog/qspi_ctrl.sv */
/*
 * quad-SPI memory controller, single chip select
 * byte/halfword/word reads and writes at a 24-bit flash address
 */
`timescale 1ns/1ps
`default_nettype none

module qspi_ctrl
	import qspi_pkg::*;
#(
	parameter int SCK_DIV = 3,
	parameter logic [7:0] READ_CMD = 8'heb,
	parameter logic [7:0] WRITE_CMD = 8'h38,
	parameter int READ_DUMMY = 6
) (
	input  logic clk,
	input  logic rst_n,
	input  logic read_req,
	input  logic write_req,
	input  xfer_size_t size,
	input  logic [ADR_W-1:0] adr,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] read_data,
	output logic read_valid,
	output logic write_finish,
	output logic busy,
	output logic sck,
	output logic ce_n,
	input  logic [NIB_W-1:0] sio_i,
	output logic [NIB_W-1:0] sio_o,
	output logic sio_en
);

	logic rise_edge;
	logic fall_edge;
	qspi_state_t state;
	logic [2:0] idx;
	logic [7:0] cmd_byte;

	qspi_xfer_if xfer ();

	qspi_sck_gen #(
		.SCK_DIV(SCK_DIV)
	) u_sck_gen (
		.clk(clk),
		.rst_n(rst_n),
		.sck(sck),
		.rise_edge(rise_edge),
		.fall_edge(fall_edge)
	);

	qspi_host_if u_host_if (
		.clk(clk),
		.rst_n(rst_n),
		.read_req(read_req),
		.write_req(write_req),
		.size(size),
		.adr(adr),
		.wdata(wdata),
		.xfer(xfer.host),
		.busy(busy)
	);

	qspi_sequencer #(
		.READ_DUMMY(READ_DUMMY),
		.READ_CMD(READ_CMD),
		.WRITE_CMD(WRITE_CMD)
	) u_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.fall_edge(fall_edge),
		.xfer(xfer.seq),
		.state(state),
		.idx(idx),
		.cmd_byte(cmd_byte),
		.ce_n(ce_n)
	);

	qspi_shifter u_shifter (
		.clk(clk),
		.rst_n(rst_n),
		.rise_edge(rise_edge),
		.state(state),
		.idx(idx),
		.cmd_byte(cmd_byte),
		.xfer(xfer.shift),
		.sio_i(sio_i),
		.sio_o(sio_o),
		.sio_en(sio_en),
		.read_data(read_data)
	);

	// done splits by direction
	assign read_valid = xfer.done & xfer.start_read;
	assign write_finish = xfer.done & xfer.start_write;

endmodule

`default_nettype wire

/* test/qspi_flash_model.sv */
/*
 * behavioral quad-SPI flash
 * decodes command and address, stores written bytes, returns read bytes
 */
`timescale 1ns/1ps
`default_nettype none

module qspi_flash_model
	import qspi_pkg::*;
#(
	parameter logic [7:0] READ_CMD = 8'heb,
	parameter logic [7:0] WRITE_CMD = 8'h38,
	parameter int READ_DUMMY = 6
) (
	input  logic sck,
	input  logic ce_n,
	input  logic [NIB_W-1:0] sio_in,
	output logic [NIB_W-1:0] sio_out,
	output int err_cnt
);

	localparam int HDR_EDGES = 8 + ADR_NIBBLES;

	logic [7:0] mem [logic [ADR_W-1:0]];
	int bit_cnt = 0;
	int fall_cnt = 0;
	logic [7:0] cmd_reg = '0;
	logic [ADR_W-1:0] adr_reg = '0;
	logic [ADR_W-1:0] wr_ptr = '0;
	logic [ADR_W-1:0] rd_ptr = '0;
	logic [3:0] wr_hi = '0;
	logic wr_low_next = 1'b0;
	logic rd_low_next = 1'b0;
	logic [7:0] rd_byte = '0;

	initial begin
		sio_out = '0;
		err_cnt = 0;
	end

	// erased pattern for bytes never written
	function automatic logic [7:0] stored_byte(input logic [ADR_W-1:0] a);
		if (mem.exists(a))
			return mem[a];
		return 8'ha5;
	endfunction

	// command, address and write nibbles on rising SCK
	always @(posedge sck) begin
		if (ce_n) begin
			bit_cnt = 0;
			wr_low_next = 1'b0;
		end else begin
			if (bit_cnt < 8) begin
				cmd_reg = {cmd_reg[6:0], sio_in[0]};
				if (bit_cnt == 7 && cmd_reg != READ_CMD && cmd_reg != WRITE_CMD) begin
					err_cnt++;
					$display("flash model: unknown command byte %h", cmd_reg);
				end
			end else if (bit_cnt < HDR_EDGES) begin
				adr_reg = {adr_reg[ADR_W-NIB_W-1:0], sio_in};
				wr_ptr = adr_reg;
			end else if (cmd_reg == WRITE_CMD) begin
				if (wr_low_next) begin
					mem[wr_ptr] = {wr_hi, sio_in};
					wr_ptr = wr_ptr + 1'b1;
				end else begin
					wr_hi = sio_in;
				end
				wr_low_next = ~wr_low_next;
			end
			bit_cnt++;
		end
	end

	// read data changes on falling SCK once the dummy cycles are over
	always @(negedge sck) begin
		if (ce_n) begin
			fall_cnt = 0;
			rd_low_next = 1'b0;
			sio_out = '0;
		end else if (bit_cnt >= HDR_EDGES && cmd_reg == READ_CMD) begin
			fall_cnt++;
			if (fall_cnt == 1)
				rd_ptr = adr_reg;
			if (fall_cnt > READ_DUMMY) begin
				if (rd_low_next) begin
					sio_out = rd_byte[3:0];
					rd_ptr = rd_ptr + 1'b1;
				end else begin
					rd_byte = stored_byte(rd_ptr);
					sio_out = rd_byte[7:4];
				end
				rd_low_next = ~rd_low_next;
			end
		end
	end

endmodule

`default_nettype wire

/* test/tb_qspi_ctrl.sv */
/*
 * testbench for the quad-SPI memory controller
 * directed reads and writes against a behavioral flash
 */
`timescale 1ns/1ps
`default_nettype none

module tb_qspi_ctrl
	import qspi_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS = 10;
	localparam int CLKS_PER_TEST = 2000;
	localparam int DONE_LIMIT = 1000;
	localparam int BUSY_WINDOW = 640;
	// clk cycles per SCK cycle with the default divider
	localparam int SCK_CLKS = 8;

	logic clk = 1'b0;
	logic rst_n;
	logic read_req;
	logic write_req;
	xfer_size_t size;
	logic [ADR_W-1:0] adr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] read_data;
	logic read_valid;
	logic write_finish;
	logic busy;
	logic sck;
	logic ce_n;
	logic [NIB_W-1:0] sio_i;
	logic [NIB_W-1:0] sio_o;
	logic sio_en;
	int flash_errors;

	int errors = 0;
	integer seed = 32'hbfe560a2;
	logic [ADR_W-1:0] word_adr;
	logic [DATA_W-1:0] word_data;

	always #(CLK_PERIOD / 2) clk = ~clk;

	qspi_ctrl u_qspi_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.read_req(read_req),
		.write_req(write_req),
		.size(size),
		.adr(adr),
		.wdata(wdata),
		.read_data(read_data),
		.read_valid(read_valid),
		.write_finish(write_finish),
		.busy(busy),
		.sck(sck),
		.ce_n(ce_n),
		.sio_i(sio_i),
		.sio_o(sio_o),
		.sio_en(sio_en)
	);

	qspi_flash_model #(
		.READ_CMD(8'heb),
		.WRITE_CMD(8'h38),
		.READ_DUMMY(6)
	) u_flash (
		.sck(sck),
		.ce_n(ce_n),
		.sio_in(sio_o),
		.sio_out(sio_i),
		.err_cnt(flash_errors)
	);

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// one request pulse, then wait for valid or finish
	task automatic run_transfer(input logic is_read, input xfer_size_t sz,
			input logic [ADR_W-1:0] a, input logic [DATA_W-1:0] d,
			output logic [DATA_W-1:0] rdata);
		int n;
		int wr_nibs;
		int en_clks;
		int exp_en;
		logic seen;
		seen = 1'b0;
		en_clks = 0;
		rdata = '0;
		case (sz)
			size_byte: wr_nibs = 2;
			size_half: wr_nibs = 4;
			default: wr_nibs = 8;
		endcase
		// bus driven for the command bits, address nibbles and write nibbles
		exp_en = (8 + ADR_NIBBLES) * SCK_CLKS;
		if (!is_read)
			exp_en = exp_en + wr_nibs * SCK_CLKS;
		@(negedge clk);
		read_req = is_read;
		write_req = ~is_read;
		size = sz;
		adr = a;
		wdata = d;
		@(negedge clk);
		read_req = 1'b0;
		write_req = 1'b0;
		for (n = 0; n < DONE_LIMIT && !seen; n++) begin
			@(negedge clk);
			check_value("busy during transfer", 32'(busy), 32'd1);
			if (sio_en)
				en_clks++;
			if (is_read && read_valid) begin
				seen = 1'b1;
				rdata = read_data;
				check_value("write_finish with read_valid", 32'(write_finish), 32'd0);
			end else if (!is_read && write_finish) begin
				seen = 1'b1;
				check_value("read_valid with write_finish", 32'(read_valid), 32'd0);
			end
		end
		if (!seen) begin
			errors++;
			$display("%s at %h did not complete within %0d clocks",
				is_read ? "read" : "write", a, DONE_LIMIT);
		end else begin
			@(negedge clk);
			if (sio_en)
				en_clks++;
			check_value("busy after completion", 32'(busy), 32'd0);
			check_value("sio_en clocks", 32'(en_clks), 32'(exp_en));
		end
	endtask

	task automatic reset_and_idle();
		int n;
		check_value("sck after reset", 32'(sck), 32'd1);
		check_value("ce_n after reset", 32'(ce_n), 32'd1);
		check_value("sio_en after reset", 32'(sio_en), 32'd0);
		check_value("busy after reset", 32'(busy), 32'd0);
		check_value("read_valid after reset", 32'(read_valid), 32'd0);
		check_value("write_finish after reset", 32'(write_finish), 32'd0);
		for (n = 0; n < 40; n++) begin
			@(negedge clk);
			check_value("ce_n while idle", 32'(ce_n), 32'd1);
		end
	endtask

	task automatic word_roundtrip();
		logic [31:0] rnd;
		logic [31:0] got;
		rnd = $random(seed);
		word_adr = {2'b00, rnd[21:0]};
		word_data = $random(seed);
		run_transfer(1'b0, size_word, word_adr, word_data, got);
		run_transfer(1'b1, size_word, word_adr, '0, got);
		check_value("word read back", got, word_data);
	endtask

	// separate address regions keep the tests from overlapping
	task automatic byte_and_half();
		logic [31:0] rnd;
		logic [31:0] data_b;
		logic [31:0] data_h;
		logic [31:0] got;
		logic [ADR_W-1:0] adr_b;
		logic [ADR_W-1:0] adr_h;
		rnd = $random(seed);
		adr_b = {2'b01, rnd[21:2], 2'b00};
		rnd = $random(seed);
		adr_h = {2'b10, rnd[21:2], 2'b00};
		data_b = $random(seed);
		data_h = $random(seed);
		run_transfer(1'b0, size_byte, adr_b, data_b, got);
		run_transfer(1'b0, size_half, adr_h, data_h, got);
		run_transfer(1'b1, size_byte, adr_b, '0, got);
		check_value("byte read back", got, {24'd0, data_b[7:0]});
		run_transfer(1'b1, size_half, adr_h, '0, got);
		check_value("halfword read back", got, {16'd0, data_h[15:0]});
		// upper byte of the halfword lives at the next address
		run_transfer(1'b1, size_byte, adr_h + 1'b1, '0, got);
		check_value("halfword upper byte", got, {24'd0, data_h[15:8]});
		run_transfer(1'b1, size_word, adr_b, '0, got);
		check_value("word over a single byte", got, {24'ha5a5a5, data_b[7:0]});
	endtask

	task automatic unwritten_word();
		logic [31:0] rnd;
		logic [31:0] got;
		rnd = $random(seed);
		run_transfer(1'b1, size_word, {2'b11, rnd[21:0]}, '0, got);
		check_value("unwritten word", got, 32'ha5a5a5a5);
	endtask

	task automatic request_while_busy();
		int n;
		int pulses;
		logic [31:0] got;
		pulses = 0;
		got = '0;
		@(negedge clk);
		read_req = 1'b1;
		size = size_word;
		adr = word_adr;
		@(negedge clk);
		check_value("busy after acceptance", 32'(busy), 32'd1);
		// request held one more cycle with other fields
		size = size_byte;
		adr = word_adr ^ 24'h000100;
		@(negedge clk);
		read_req = 1'b0;
		for (n = 0; n < BUSY_WINDOW; n++) begin
			@(negedge clk);
			if (read_valid) begin
				pulses++;
				got = read_data;
			end
		end
		check_value("read_valid pulses", 32'(pulses), 32'd1);
		check_value("data of the accepted read", got, word_data);
		check_value("busy after the transfer", 32'(busy), 32'd0);
	endtask

	initial begin
		rst_n = 1'b0;
		read_req = 1'b0;
		write_req = 1'b0;
		size = size_byte;
		adr = '0;
		wdata = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		reset_and_idle();
		word_roundtrip();
		byte_and_half();
		unwritten_word();
		request_while_busy();
		check_value("flash model error count", 32'(flash_errors), 32'd0);
		$display("summary: %0d errors, %0d flash model errors", errors, flash_errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// budget for the whole run
	initial begin
		#(NUM_TESTS * CLKS_PER_TEST * CLK_PERIOD);
		$display("timeout: tests did not finish within %0d clocks",
			NUM_TESTS * CLKS_PER_TEST);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
verilog/qspi_pkg.sv
verilog/qspi_xfer_if.sv
verilog/qspi_sck_gen.sv
verilog/qspi_host_if.sv
verilog/qspi_sequencer.sv
verilog/qspi_shifter.sv
verilog/qspi_ctrl.sv
test/qspi_flash_model.sv
test/tb_qspi_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the quad-SPI controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module tb_qspi_ctrl -Mdir obj_dir -o sim_tb; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^No errors$" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
